/* files.f */
+incdir+sim
verilog/mem_pkg.sv
verilog/mem_req_if.sv
verilog/mem_resp_if.sv
verilog/mem_arbiter.sv
verilog/protected_mem.sv
verilog/mem_subsystem.sv
sim/mem_subsystem_tb.sv

/* sim/mem_tb_checks.svh */
//##########################################################
// Reference model, random source and compare tasks for the
// memory subsystem testbench.
//##########################################################

// Linear congruential generator.
function automatic logic [31:0] lcg_next(input logic [31:0] state);
	return state * 32'd1103515245 + 32'd12345;
endfunction

// Applies the protection rule to the model array.
function automatic exp_t ref_access(
	input logic [mem_pkg::req_ctl_nbits-1:0] control,
	input logic [mem_pkg::data_nbits-1:0]    wdata,
	input logic                              domain
);
	exp_t                           r;
	logic [mem_pkg::addr_nbits-1:0] addr;
	logic [7:0]                     idx;
	logic                           is_write;
	logic                           blocked;
	addr     = control[mem_pkg::req_addr_lsb +: mem_pkg::addr_nbits];
	idx      = addr[9:2];
	is_write = (control[mem_pkg::req_type_bit] == mem_pkg::type_write);
	blocked  = (idx >= mem_pkg::secure_base) && (domain == mem_pkg::domain_insecure);
	r.ctl = '0;
	r.ctl[mem_pkg::resp_opaque_lsb +: mem_pkg::opaque_nbits] =
		control[mem_pkg::req_opaque_lsb +: mem_pkg::opaque_nbits];
	r.ctl[mem_pkg::resp_type_bit] = control[mem_pkg::req_type_bit];
	r.data     = '0;
	r.insecure = blocked;
	r.domain   = domain;
	if (!blocked && is_write) begin
		model_mem[idx] = wdata;
	end else if (!blocked) begin
		r.data = model_mem[idx];
	end
	return r;
endfunction

task automatic check_resp_ctl(input string name,
		input logic [mem_pkg::resp_ctl_nbits-1:0] exp,
		input logic [mem_pkg::resp_ctl_nbits-1:0] act);
	if (act !== exp) begin
		abort_run($sformatf("FAIL %s: expected %h, got %h", name, exp, act));
	end
endtask

task automatic check_data(input string name,
		input logic [mem_pkg::data_nbits-1:0] exp,
		input logic [mem_pkg::data_nbits-1:0] act);
	if (act !== exp) begin
		abort_run($sformatf("FAIL %s: expected %h, got %h", name, exp, act));
	end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		abort_run($sformatf("FAIL %s: expected %b, got %b", name, exp, act));
	end
endtask

/* sim/mem_subsystem_tb.sv */
//##########################################################
// Testbench for the two-port protected memory subsystem.
//##########################################################

`timescale 1ns/1ps

module mem_subsystem_tb;

	typedef struct packed {
		logic [mem_pkg::resp_ctl_nbits-1:0] ctl;
		logic [mem_pkg::data_nbits-1:0]     data;
		logic                               insecure;
		logic                               domain;
	} exp_t;

	// About 230 transactions of 8 cycles, plus stalls.
	localparam int max_cycles = 4000;

	logic                               clk = 1'b0;
	logic                               reset;
	logic                               req_val [0:1];
	logic                               req_rdy [0:1];
	logic [mem_pkg::req_ctl_nbits-1:0]  req_control [0:1];
	logic [mem_pkg::data_nbits-1:0]     req_data [0:1];
	logic                               req_domain [0:1];
	logic                               resp_val [0:1];
	logic                               resp_rdy [0:1] = '{1'b1, 1'b1};
	logic [mem_pkg::resp_ctl_nbits-1:0] resp_control [0:1];
	logic [mem_pkg::data_nbits-1:0]     resp_data [0:1];
	logic                               resp_insecure [0:1];
	logic                               resp_domain [0:1];

	logic                               hold_rdy [0:1];
	logic                               stall_on;
	logic [31:0]                        rand_state;
	logic [31:0]                        stall_state;
	logic [mem_pkg::data_nbits-1:0]     model_mem [0:mem_pkg::mem_words-1];
	int                                 cycle_count = 0;
	int                                 grant_count;
	int                                 grant_order [0:1];
	string                              test_name;
	exp_t                               exp_q0 [$];
	exp_t                               exp_q1 [$];
	logic                               held_valid [0:1];
	exp_t                               held_snap [0:1];

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	`include "mem_tb_checks.svh"

	function automatic logic [mem_pkg::addr_nbits-1:0] word_addr(input logic [7:0] idx);
		return {22'b0, idx, 2'b00};
	endfunction

	// Holds val until the arbiter's rdy, then queues the expected response.
	task automatic issue(input int p, input logic typ, input logic dom,
			input logic [mem_pkg::addr_nbits-1:0] addr,
			input logic [mem_pkg::data_nbits-1:0] wdata, input logic [7:0] tag);
		logic [mem_pkg::req_ctl_nbits-1:0] ctl;
		exp_t                              exp;
		ctl = '0;
		ctl[mem_pkg::req_addr_lsb +: mem_pkg::addr_nbits]     = addr;
		ctl[mem_pkg::req_opaque_lsb +: mem_pkg::opaque_nbits] = tag;
		ctl[mem_pkg::req_type_bit]                            = typ;
		@(posedge clk);
		#1;
		req_val[p]     = 1'b1;
		req_control[p] = ctl;
		req_data[p]    = wdata;
		req_domain[p]  = dom;
		@(negedge clk);
		while (!req_rdy[p]) begin
			@(negedge clk);
		end
		exp = ref_access(ctl, wdata, dom);
		if (p == 0) begin
			exp_q0.push_back(exp);
		end else begin
			exp_q1.push_back(exp);
		end
		grant_order[p] = grant_count;
		grant_count++;
		@(posedge clk);
		#1;
		req_val[p] = 1'b0;
	endtask

	task automatic drain();
		while (exp_q0.size() != 0 || exp_q1.size() != 0) begin
			@(negedge clk);
		end
		@(negedge clk);
	endtask

	function automatic exp_t snapshot(input int p);
		return '{resp_control[p], resp_data[p], resp_insecure[p], resp_domain[p]};
	endfunction

	task automatic compare_resp(input int p, input exp_t exp, input string what);
		check_resp_ctl({test_name, " ", what, " control"}, exp.ctl, resp_control[p]);
		check_data({test_name, " ", what, " data"}, exp.data, resp_data[p]);
		check_bit({test_name, " ", what, " insecure"}, exp.insecure, resp_insecure[p]);
		check_bit({test_name, " ", what, " domain"}, exp.domain, resp_domain[p]);
	endtask

	mem_subsystem uut (
		.clk            (clk),
		.reset          (reset),
		.req0_val       (req_val[0]),
		.req0_rdy       (req_rdy[0]),
		.req0_control   (req_control[0]),
		.req0_data      (req_data[0]),
		.req0_domain    (req_domain[0]),
		.req1_val       (req_val[1]),
		.req1_rdy       (req_rdy[1]),
		.req1_control   (req_control[1]),
		.req1_data      (req_data[1]),
		.req1_domain    (req_domain[1]),
		.resp0_val      (resp_val[0]),
		.resp0_rdy      (resp_rdy[0]),
		.resp0_control  (resp_control[0]),
		.resp0_data     (resp_data[0]),
		.resp0_insecure (resp_insecure[0]),
		.resp0_domain   (resp_domain[0]),
		.resp1_val      (resp_val[1]),
		.resp1_rdy      (resp_rdy[1]),
		.resp1_control  (resp_control[1]),
		.resp1_data     (resp_data[1]),
		.resp1_insecure (resp_insecure[1]),
		.resp1_domain   (resp_domain[1])
	);

	always #20 clk = ~clk;

	// Response rdy is random or held.
	always @(posedge clk) begin
		#1;
		if (stall_on) begin
			stall_state  = lcg_next(stall_state);
			resp_rdy[0]  = (stall_state[31:30] != 2'b00);
			stall_state  = lcg_next(stall_state);
			resp_rdy[1]  = (stall_state[31:30] != 2'b00);
		end else begin
			resp_rdy[0] = hold_rdy[0];
			resp_rdy[1] = hold_rdy[1];
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= max_cycles) begin
			abort_run("Timeout: the run did not finish within the cycle limit.");
		end
	end

	//##########################################################
	// Response compare
	//##########################################################

	always @(negedge clk) begin
		exp_t exp;
		if (!reset) begin
			for (int p = 0; p < 2; p++) begin
				if (held_valid[p]) begin
					check_bit({test_name, " held val"}, 1'b1, resp_val[p]);
					compare_resp(p, held_snap[p], "held");
				end
				held_valid[p] = resp_val[p] && !resp_rdy[p];
				held_snap[p]  = snapshot(p);
				if (resp_val[p] && resp_rdy[p]) begin
					if ((p == 0) ? (exp_q0.size() == 0) : (exp_q1.size() == 0)) begin
						abort_run($sformatf(
							"Response on port %0d with no request outstanding.", p));
					end
					exp = (p == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
					compare_resp(p, exp, "response");
				end
			end
			if (resp_val[0] || resp_val[1]) begin
				check_bit({test_name, " grant during response"}, 1'b0, req_rdy[0] || req_rdy[1]);
			end
		end
	end

	//##########################################################
	// Test sequence
	//##########################################################

	initial begin
		logic [31:0] r;
		logic [31:0] hi;
		reset       = 1'b1;
		req_val     = '{1'b0, 1'b0};
		req_control = '{'0, '0};
		req_data    = '{'0, '0};
		req_domain  = '{1'b0, 1'b0};
		hold_rdy    = '{1'b1, 1'b1};
		held_valid  = '{1'b0, 1'b0};
		stall_on    = 1'b0;
		rand_state  = 32'd40;
		stall_state = lcg_next(32'd40);
		grant_count = 0;
		test_name   = "reset";
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		check_bit("reset req0_rdy", 1'b0, req_rdy[0]);
		check_bit("reset req1_rdy", 1'b0, req_rdy[1]);
		check_bit("reset resp0_val", 1'b0, resp_val[0]);
		check_bit("reset resp1_val", 1'b0, resp_val[1]);
		check_bit("reset link req val", 1'b0, uut.mem_req_link.val);
		check_bit("reset link resp val", 1'b0, uut.mem_resp_link.val);

		test_name = "write read";
		issue(0, mem_pkg::type_write, mem_pkg::domain_secure, word_addr(8'd10), 32'hcafe0010, 8'h11);
		issue(0, mem_pkg::type_read, mem_pkg::domain_secure, word_addr(8'd10), '0, 8'h12);
		issue(1, mem_pkg::type_write, mem_pkg::domain_secure, word_addr(8'd140), 32'hbeef0140, 8'h21);
		issue(1, mem_pkg::type_read, mem_pkg::domain_secure, word_addr(8'd140), '0, 8'h22);
		drain();

		test_name = "protection";
		issue(1, mem_pkg::type_read, mem_pkg::domain_insecure, word_addr(8'd140), '0, 8'h31);
		issue(0, mem_pkg::type_write, mem_pkg::domain_insecure, word_addr(8'd140), 32'h0bad0bad, 8'h32);
		issue(0, mem_pkg::type_read, mem_pkg::domain_secure, word_addr(8'd140), '0, 8'h33);
		issue(1, mem_pkg::type_write, mem_pkg::domain_insecure, word_addr(8'd20), 32'h12340020, 8'h34);
		issue(0, mem_pkg::type_read, mem_pkg::domain_insecure, word_addr(8'd20), '0, 8'h35);
		drain();

		test_name = "priority";
		fork
			issue(0, mem_pkg::type_write, mem_pkg::domain_secure, word_addr(8'd30), 32'h30, 8'h40);
			issue(1, mem_pkg::type_write, mem_pkg::domain_secure, word_addr(8'd31), 32'h31, 8'h41);
		join
		check_bit("priority grant order", 1'b1, grant_order[0] < grant_order[1]);
		drain();

		test_name = "latency";
		fork
			issue(0, mem_pkg::type_read, mem_pkg::domain_secure, word_addr(8'd10), '0, 8'h50);
			begin
				// Second edge is the one that samples the request.
				repeat (2) @(posedge clk);
				repeat (2) begin
					@(negedge clk);
					check_bit("latency early resp0_val", 1'b0, resp_val[0]);
				end
				@(negedge clk);
				check_bit("latency resp0_val", 1'b1, resp_val[0]);
			end
		join
		drain();

		test_name = "back-pressure";
		hold_rdy[1] = 1'b0;
		fork
			issue(1, mem_pkg::type_read, mem_pkg::domain_secure, word_addr(8'd140), '0, 8'h60);
			begin
				repeat (2) @(posedge clk);
				issue(0, mem_pkg::type_read, mem_pkg::domain_secure, word_addr(8'd30), '0, 8'h61);
			end
			begin
				@(negedge clk);
				while (!resp_val[1]) begin
					@(negedge clk);
				end
				repeat (5) @(negedge clk);
				hold_rdy[1] = 1'b1;
			end
		join
		drain();

		// Pool of words 0..7 and 128..135 gets known contents.
		test_name = "random";
		for (int i = 0; i < 16; i++) begin
			rand_state = lcg_next(rand_state);
			issue(i % 2, mem_pkg::type_write, mem_pkg::domain_secure,
				word_addr({i[3], 4'b0000, i[2:0]}), rand_state, i[7:0]);
		end
		stall_on = 1'b1;
		for (int i = 0; i < 200; i++) begin
			rand_state = lcg_next(rand_state);
			r          = rand_state;
			rand_state = lcg_next(rand_state);
			hi         = rand_state;
			rand_state = lcg_next(rand_state);
			issue(r[31], r[30], r[29], {hi[31:10], r[28], 4'b0000, r[27:25], hi[1:0]},
				rand_state, r[23:16]);
		end
		drain();
		stall_on = 1'b0;

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* verilog/mem_arbiter.sv */
//##########################################################
// Two-port fixed-priority arbiter. Serializes requests
// onto one memory link and routes each response back.
//##########################################################

`timescale 1ns/1ps

module mem_arbiter (
	input logic         clk,
	input logic         reset,

	mem_req_if.slave    req0,
	mem_req_if.slave    req1,
	mem_resp_if.master  resp0,
	mem_resp_if.master  resp1,

	mem_req_if.master   mem_req,
	mem_resp_if.slave   mem_resp
);

	logic [mem_pkg::state_nbits-1:0]    state_reg;
	logic [mem_pkg::state_nbits-1:0]    state_next;

	logic                               req_en;
	logic                               resp_en;
	logic                               sel1;

	logic [mem_pkg::req_ctl_nbits-1:0]  req0_control_reg;
	logic [mem_pkg::data_nbits-1:0]     req0_data_reg;
	logic                               req0_domain_reg;
	logic [mem_pkg::req_ctl_nbits-1:0]  req1_control_reg;
	logic [mem_pkg::data_nbits-1:0]     req1_data_reg;
	logic                               req1_domain_reg;

	logic [mem_pkg::resp_ctl_nbits-1:0] resp_control_reg;
	logic [mem_pkg::data_nbits-1:0]     resp_data_reg;
	logic                               resp_insecure_reg;
	logic                               resp_domain_reg;

	//##########################################################
	// State machine
	//##########################################################

	always_ff @(posedge clk) begin
		if (reset) begin
			state_reg <= mem_pkg::st_idle;
		end else begin
			state_reg <= state_next;
		end
	end

	always_comb begin
		state_next = state_reg;
		case (state_reg)
			mem_pkg::st_idle: begin
				// Port 0 always wins.
				if (req0.val) begin
					state_next = mem_pkg::st_req0;
				end else if (req1.val) begin
					state_next = mem_pkg::st_req1;
				end
			end
			mem_pkg::st_req0: begin
				if (mem_req.rdy) begin
					state_next = mem_pkg::st_wait0;
				end
			end
			mem_pkg::st_req1: begin
				if (mem_req.rdy) begin
					state_next = mem_pkg::st_wait1;
				end
			end
			mem_pkg::st_wait0: begin
				if (mem_resp.val) begin
					state_next = mem_pkg::st_resp0;
				end
			end
			mem_pkg::st_wait1: begin
				if (mem_resp.val) begin
					state_next = mem_pkg::st_resp1;
				end
			end
			mem_pkg::st_resp0: begin
				if (resp0.rdy) begin
					state_next = mem_pkg::st_idle;
				end
			end
			mem_pkg::st_resp1: begin
				if (resp1.rdy) begin
					state_next = mem_pkg::st_idle;
				end
			end
			default: begin
				state_next = mem_pkg::st_idle;
			end
		endcase
	end

	assign req_en  = (state_reg == mem_pkg::st_idle);
	assign resp_en = (state_reg == mem_pkg::st_wait0) || (state_reg == mem_pkg::st_wait1);
	assign sel1    = (state_reg == mem_pkg::st_req1);

	//##########################################################
	// Capture registers
	//##########################################################

	// Both ports are sampled every idle cycle.
	always_ff @(posedge clk) begin
		if (req_en) begin
			req0_control_reg <= req0.control;
			req0_data_reg    <= req0.data;
			req0_domain_reg  <= req0.domain;
			req1_control_reg <= req1.control;
			req1_data_reg    <= req1.data;
			req1_domain_reg  <= req1.domain;
		end
	end

	// Last load is the edge where the response is seen.
	always_ff @(posedge clk) begin
		if (resp_en) begin
			resp_control_reg  <= mem_resp.control;
			resp_data_reg     <= mem_resp.data;
			resp_insecure_reg <= mem_resp.insecure;
			resp_domain_reg   <= mem_resp.domain;
		end
	end

	//##########################################################
	// Memory link
	//##########################################################

	assign mem_req.val     = (state_reg == mem_pkg::st_req0) || sel1;
	assign mem_req.control = sel1 ? req1_control_reg : req0_control_reg;
	assign mem_req.data    = sel1 ? req1_data_reg : req0_data_reg;
	assign mem_req.domain  = sel1 ? req1_domain_reg : req0_domain_reg;

	// Requester ready only on the accepting cycle.
	assign req0.rdy = (state_reg == mem_pkg::st_req0) && mem_req.rdy;
	assign req1.rdy = sel1 && mem_req.rdy;

	assign mem_resp.rdy = resp_en;

	//##########################################################
	// Response ports
	//##########################################################

	assign resp0.val      = (state_reg == mem_pkg::st_resp0);
	assign resp0.control  = resp_control_reg;
	assign resp0.data     = resp_data_reg;
	assign resp0.insecure = resp_insecure_reg;
	assign resp0.domain   = resp_domain_reg;

	assign resp1.val      = (state_reg == mem_pkg::st_resp1);
	assign resp1.control  = resp_control_reg;
	assign resp1.data     = resp_data_reg;
	assign resp1.insecure = resp_insecure_reg;
	assign resp1.domain   = resp_domain_reg;

endmodule

/* verilog/mem_pkg.sv */
//##########################################################
// Shared widths, field positions and memory geometry for
// the two-port protected memory subsystem.
//##########################################################

package mem_pkg;

	// Message widths.
	localparam int data_nbits     = 32;
	localparam int opaque_nbits   = 8;
	localparam int addr_nbits     = 32;
	localparam int req_ctl_nbits  = addr_nbits + opaque_nbits + 1;
	localparam int resp_ctl_nbits = opaque_nbits + 1;

	// Request control is {type, opaque, addr}.
	localparam int req_addr_lsb   = 0;
	localparam int req_opaque_lsb = req_addr_lsb + addr_nbits;
	localparam int req_type_bit   = req_opaque_lsb + opaque_nbits;

	// Response control is {type, opaque}.
	localparam int resp_opaque_lsb = 0;
	localparam int resp_type_bit   = resp_opaque_lsb + opaque_nbits;

	localparam logic type_read  = 1'b0;
	localparam logic type_write = 1'b1;

	// Word array, indexed by address bits 9:2.
	localparam int mem_words      = 256;
	localparam int word_idx_lsb   = 2;
	localparam int word_idx_nbits = $clog2(mem_words);

	// Upper half is secure.
	localparam int secure_base = 128;

	localparam logic domain_secure   = 1'b1;
	localparam logic domain_insecure = 1'b0;

	// Arbiter state encoding.
	localparam int state_nbits = 3;
	localparam logic [state_nbits-1:0] st_idle  = 3'd0;
	localparam logic [state_nbits-1:0] st_req0  = 3'd1;
	localparam logic [state_nbits-1:0] st_req1  = 3'd2;
	localparam logic [state_nbits-1:0] st_wait0 = 3'd3;
	localparam logic [state_nbits-1:0] st_wait1 = 3'd4;
	localparam logic [state_nbits-1:0] st_resp0 = 3'd5;
	localparam logic [state_nbits-1:0] st_resp1 = 3'd6;

endpackage

/* verilog/mem_req_if.sv */
//##########################################################
// Memory request link with valid/ready handshake.
//##########################################################

`timescale 1ns/1ps

interface mem_req_if;

	logic                               val;
	logic                               rdy;
	logic [mem_pkg::req_ctl_nbits-1:0]  control;
	logic [mem_pkg::data_nbits-1:0]     data;
	logic                               domain;

	modport master (
		output val,
		input  rdy,
		output control,
		output data,
		output domain
	);

	modport slave (
		input  val,
		output rdy,
		input  control,
		input  data,
		input  domain
	);

endinterface

/* verilog/mem_resp_if.sv */
//##########################################################
// Memory response link with valid/ready handshake,
// carrying the protection flag and the echoed domain.
//##########################################################

`timescale 1ns/1ps

interface mem_resp_if;

	logic                               val;
	logic                               rdy;
	logic [mem_pkg::resp_ctl_nbits-1:0] control;
	logic [mem_pkg::data_nbits-1:0]     data;
	logic                               insecure;
	logic                               domain;

	modport master (
		output val,
		input  rdy,
		output control,
		output data,
		output insecure,
		output domain
	);

	// Receiving side.
	modport slave (
		input  val,
		output rdy,
		input  control,
		input  data,
		input  insecure,
		input  domain
	);

endinterface

/* verilog/mem_subsystem.sv */
//##########################################################
// Shared memory port: arbiter plus protected memory.
//##########################################################

`timescale 1ns/1ps

module mem_subsystem (
	input  logic                               clk,
	input  logic                               reset,

	input  logic                               req0_val,
	output logic                               req0_rdy,
	input  logic [mem_pkg::req_ctl_nbits-1:0]  req0_control,
	input  logic [mem_pkg::data_nbits-1:0]     req0_data,
	input  logic                               req0_domain,

	input  logic                               req1_val,
	output logic                               req1_rdy,
	input  logic [mem_pkg::req_ctl_nbits-1:0]  req1_control,
	input  logic [mem_pkg::data_nbits-1:0]     req1_data,
	input  logic                               req1_domain,

	output logic                               resp0_val,
	input  logic                               resp0_rdy,
	output logic [mem_pkg::resp_ctl_nbits-1:0] resp0_control,
	output logic [mem_pkg::data_nbits-1:0]     resp0_data,
	output logic                               resp0_insecure,
	output logic                               resp0_domain,

	output logic                               resp1_val,
	input  logic                               resp1_rdy,
	output logic [mem_pkg::resp_ctl_nbits-1:0] resp1_control,
	output logic [mem_pkg::data_nbits-1:0]     resp1_data,
	output logic                               resp1_insecure,
	output logic                               resp1_domain
);

	mem_req_if  req0_if ();
	mem_req_if  req1_if ();
	mem_resp_if resp0_if ();
	mem_resp_if resp1_if ();

	// Arbiter to memory.
	mem_req_if  mem_req_link ();
	mem_resp_if mem_resp_link ();

	assign req0_if.val     = req0_val;
	assign req0_if.control = req0_control;
	assign req0_if.data    = req0_data;
	assign req0_if.domain  = req0_domain;
	assign req0_rdy        = req0_if.rdy;

	assign req1_if.val     = req1_val;
	assign req1_if.control = req1_control;
	assign req1_if.data    = req1_data;
	assign req1_if.domain  = req1_domain;
	assign req1_rdy        = req1_if.rdy;

	assign resp0_val      = resp0_if.val;
	assign resp0_control  = resp0_if.control;
	assign resp0_data     = resp0_if.data;
	assign resp0_insecure = resp0_if.insecure;
	assign resp0_domain   = resp0_if.domain;
	assign resp0_if.rdy   = resp0_rdy;

	assign resp1_val      = resp1_if.val;
	assign resp1_control  = resp1_if.control;
	assign resp1_data     = resp1_if.data;
	assign resp1_insecure = resp1_if.insecure;
	assign resp1_domain   = resp1_if.domain;
	assign resp1_if.rdy   = resp1_rdy;

	mem_arbiter arbiter (
		.clk      (clk),
		.reset    (reset),
		.req0     (req0_if),
		.req1     (req1_if),
		.resp0    (resp0_if),
		.resp1    (resp1_if),
		.mem_req  (mem_req_link),
		.mem_resp (mem_resp_link)
	);

	protected_mem mem (
		.clk   (clk),
		.reset (reset),
		.req   (mem_req_link),
		.resp  (mem_resp_link)
	);

endmodule

/* verilog/protected_mem.sv */
//##########################################################
// Single-port word memory. Insecure accesses to the upper
// half are blocked and flagged in the response.
//##########################################################

`timescale 1ns/1ps

module protected_mem (
	input logic         clk,
	input logic         reset,

	mem_req_if.slave    req,
	mem_resp_if.master  resp
);

	logic [mem_pkg::data_nbits-1:0]     mem_array [0:mem_pkg::mem_words-1];

	logic                               pending;
	logic                               accept;
	logic                               blocked;

	logic [mem_pkg::addr_nbits-1:0]     addr;
	logic [mem_pkg::opaque_nbits-1:0]   opaque;
	logic                               req_type;
	logic [mem_pkg::word_idx_nbits-1:0] word_idx;
	logic [mem_pkg::resp_ctl_nbits-1:0] resp_ctl_next;

	logic [mem_pkg::resp_ctl_nbits-1:0] resp_control_reg;
	logic [mem_pkg::data_nbits-1:0]     resp_data_reg;
	logic                               resp_insecure_reg;
	logic                               resp_domain_reg;

	// Request fields.
	assign addr     = req.control[mem_pkg::req_addr_lsb +: mem_pkg::addr_nbits];
	assign opaque   = req.control[mem_pkg::req_opaque_lsb +: mem_pkg::opaque_nbits];
	assign req_type = req.control[mem_pkg::req_type_bit];
	assign word_idx = addr[mem_pkg::word_idx_lsb +: mem_pkg::word_idx_nbits];

	assign blocked = (word_idx >= mem_pkg::secure_base)
		&& (req.domain == mem_pkg::domain_insecure);

	always_comb begin
		resp_ctl_next = '0;
		resp_ctl_next[mem_pkg::resp_opaque_lsb +: mem_pkg::opaque_nbits] = opaque;
		resp_ctl_next[mem_pkg::resp_type_bit] = req_type;
	end

	// One response outstanding at most.
	assign req.rdy = !pending;
	assign accept  = req.val && !pending;

	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= 1'b0;
		end else if (accept) begin
			pending <= 1'b1;
		end else if (resp.rdy) begin
			pending <= 1'b0;
		end
	end

	// Array write.
	always_ff @(posedge clk) begin
		if (accept && (req_type == mem_pkg::type_write) && !blocked) begin
			mem_array[word_idx] <= req.data;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			resp_control_reg  <= resp_ctl_next;
			resp_insecure_reg <= blocked;
			resp_domain_reg   <= req.domain;
			// Writes and blocked reads return zero.
			if ((req_type == mem_pkg::type_read) && !blocked) begin
				resp_data_reg <= mem_array[word_idx];
			end else begin
				resp_data_reg <= '0;
			end
		end
	end

	assign resp.val      = pending;
	assign resp.control  = resp_control_reg;
	assign resp.data     = resp_data_reg;
	assign resp.insecure = resp_insecure_reg;
	assign resp.domain   = resp_domain_reg;

endmodule
